// ==== verilog/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////

    localparam int ADDR_W         = 32;
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 7;
    localparam int OFFSET_W       = 5;
    localparam int NUM_SETS       = 128;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = 256;
    localparam int NUM_WAYS       = 2;

    //////////////////////////////
    // types
    //////////////////////////////

    // physical address split, tag on top
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } paddr_t;

    // one tag array entry
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tagv_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

    typedef struct packed {
        logic        rvalid;
        logic        wvalid;
        paddr_t      addr;
        logic [3:0]  wsel;
        logic [31:0] wdata;
    } cpu_req_t;

    // line read request, addr is line aligned
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
    } mem_rd_t;

    // line write request for write-back
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        line_t             data;
    } mem_wr_t;

    typedef enum logic [1:0] {
        miss_idle,
        miss_writeback,
        miss_refill
    } miss_state_e;

endpackage

`default_nettype wire

// ==== verilog/dcache_req_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_req_stage (
    input  wire                             clk,
    input  wire                             rst,
    input  dcache_pkg::cpu_req_t            req_i,
    input  wire                             stall_i,
    output dcache_pkg::cpu_req_t            s2_req_o,
    output logic [dcache_pkg::INDEX_W-1:0]  rd_index_o
);

    // request kind, cleared by reset
    logic rvalid_q;
    logic wvalid_q;

    // payload
    dcache_pkg::paddr_t addr_q;
    logic [3:0]         wsel_q;
    logic [31:0]        wdata_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rvalid_q <= 1'b0;
            wvalid_q <= 1'b0;
        end else if (!stall_i) begin
            rvalid_q <= req_i.rvalid;
            wvalid_q <= req_i.wvalid;
        end
    end

    // payload only moves with the pipe
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            addr_q  <= req_i.addr;
            wsel_q  <= req_i.wsel;
            wdata_q <= req_i.wdata;
        end
    end

    always_comb begin
        s2_req_o.rvalid = rvalid_q;
        s2_req_o.wvalid = wvalid_q;
        s2_req_o.addr   = addr_q;
        s2_req_o.wsel   = wsel_q;
        s2_req_o.wdata  = wdata_q;
    end

    // keep reading the stalled set
    // so the arrays show it again when the stall drops
    assign rd_index_o = stall_i ? addr_q.index : req_i.addr.index;

endmodule

`default_nettype wire

// ==== verilog/dcache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_way (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [dcache_pkg::INDEX_W-1:0]    rd_index_i,
    input  wire [dcache_pkg::INDEX_W-1:0]    wr_index_i,
    input  wire                              tag_we_i,
    input  wire [dcache_pkg::TAG_W-1:0]      wr_tag_i,
    input  wire [dcache_pkg::LINE_W/8-1:0]   byte_we_i,
    input  dcache_pkg::line_t                wr_line_i,
    output dcache_pkg::tagv_t                tagv_o,
    output dcache_pkg::line_t                line_o
);

    //////////////////////////////
    // storage
    //////////////////////////////

    logic [dcache_pkg::TAG_W-1:0]  tag_mem  [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::LINE_W-1:0] data_mem [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0] valid_q;

    // read side
    logic                          same_set;
    logic [dcache_pkg::LINE_W-1:0] wr_flat;
    logic [dcache_pkg::LINE_W-1:0] rd_flat;
    logic [dcache_pkg::TAG_W-1:0]  rd_tag_d;
    logic                          rd_valid_d;
    logic [dcache_pkg::TAG_W-1:0]  rd_tag_q;
    logic                          rd_valid_q;
    logic [dcache_pkg::LINE_W-1:0] rd_line_q;

    assign same_set = (rd_index_i == wr_index_i);
    assign wr_flat  = wr_line_i;

    //////////////////////////////
    // write-first bypass
    //////////////////////////////

    // bytes written this edge win over the stored ones
    always_comb begin
        rd_flat = data_mem[rd_index_i];
        if (same_set) begin
            for (int b = 0; b < dcache_pkg::LINE_W/8; b++) begin
                if (byte_we_i[b]) begin
                    rd_flat[b*8 +: 8] = wr_flat[b*8 +: 8];
                end
            end
        end
    end

    // tag and valid only change on refill
    assign rd_tag_d   = (same_set && tag_we_i) ? wr_tag_i : tag_mem[rd_index_i];
    assign rd_valid_d = valid_q[rd_index_i] | (same_set & tag_we_i);

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_mem[wr_index_i] <= wr_tag_i;
        end
        for (int b = 0; b < dcache_pkg::LINE_W/8; b++) begin
            if (byte_we_i[b]) begin
                data_mem[wr_index_i][b*8 +: 8] <= wr_flat[b*8 +: 8];
            end
        end
        rd_tag_q  <= rd_tag_d;
        rd_line_q <= rd_flat;
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (tag_we_i) begin
                valid_q[wr_index_i] <= 1'b1;
            end
            rd_valid_q <= rd_valid_d;
        end
    end

    assign tagv_o = '{valid: rd_valid_q, tag: rd_tag_q};
    assign line_o = rd_line_q;

endmodule

`default_nettype wire

// ==== verilog/dcache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup (
    input  dcache_pkg::cpu_req_t                           s2_req_i,
    input  dcache_pkg::tagv_t [dcache_pkg::NUM_WAYS-1:0]   way_tagv_i,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]   way_line_i,
    input  wire                                            refill_i,
    input  dcache_pkg::line_t                              ret_data_i,
    input  wire                                            victim_i,
    output logic [dcache_pkg::NUM_WAYS-1:0]                hit_way_o,
    output logic                                           hit_o,
    output logic [31:0]                                    rdata_o,
    output dcache_pkg::line_t                              wr_line_o,
    output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::LINE_W/8-1:0] byte_we_o
);

    logic                          req_valid;
    logic [2:0]                    word_sel;
    logic                          hit_idx;
    logic [31:0]                   wmask;
    logic [dcache_pkg::LINE_W/8-1:0] strobe_bytes;
    dcache_pkg::line_t             base_line;

    assign req_valid = s2_req_i.rvalid | s2_req_i.wvalid;
    assign word_sel  = s2_req_i.addr.offset[dcache_pkg::OFFSET_W-1:2];

    //////////////////////////////
    // tag compare
    //////////////////////////////

    // bubbles never hit
    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            hit_way_o[w] = req_valid & way_tagv_i[w].valid &
                           (way_tagv_i[w].tag == s2_req_i.addr.tag);
        end
    end

    assign hit_o   = |hit_way_o;
    assign hit_idx = hit_way_o[1];

    // read word, from memory on refill
    always_comb begin
        if (!s2_req_i.rvalid) begin
            rdata_o = 32'h0;
        end else if (refill_i) begin
            rdata_o = ret_data_i[word_sel];
        end else begin
            rdata_o = way_line_i[hit_idx][word_sel];
        end
    end

    //////////////////////////////
    // store merge
    //////////////////////////////

    assign wmask = {{8{s2_req_i.wsel[3]}}, {8{s2_req_i.wsel[2]}},
                    {8{s2_req_i.wsel[1]}}, {8{s2_req_i.wsel[0]}}};

    // wsel moved to the addressed word
    assign strobe_bytes = {28'b0, s2_req_i.wsel} << {word_sel, 2'b00};

    assign base_line = refill_i ? ret_data_i : way_line_i[hit_idx];

    always_comb begin
        wr_line_o = base_line;
        if (s2_req_i.wvalid) begin
            wr_line_o[word_sel] = (s2_req_i.wdata & wmask) | (base_line[word_sel] & ~wmask);
        end
    end

    // refill fills the whole victim line
    // write hit touches only the strobed bytes
    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (refill_i && (victim_i == 1'(w))) begin
                byte_we_o[w] = '1;
            end else if (s2_req_i.wvalid && hit_way_o[w]) begin
                byte_we_o[w] = strobe_bytes;
            end else begin
                byte_we_o[w] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_replace.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_replace (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [dcache_pkg::INDEX_W-1:0]    index_i,
    input  wire [dcache_pkg::NUM_WAYS-1:0]   hit_way_i,
    input  wire                              is_write_i,
    input  wire                              refill_i,
    output logic                             victim_o,
    output logic                             victim_dirty_o
);

    // lru bit names the way to replace next
    logic [dcache_pkg::NUM_SETS-1:0] lru_q;
    // dirty per way, per set
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] dirty_q;

    assign victim_o       = lru_q[index_i];
    assign victim_dirty_o = dirty_q[victim_o][index_i];

    always_ff @(posedge clk) begin
        if (!rst) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else if (refill_i) begin
            // new line becomes most recent
            lru_q[index_i]             <= ~lru_q[index_i];
            dirty_q[victim_o][index_i] <= is_write_i;
        end else if (|hit_way_i) begin
            // point away from the hit way
            lru_q[index_i] <= hit_way_i[0];
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                if (hit_way_i[w] && is_write_i) begin
                    dirty_q[w][index_i] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl (
    input  wire                                          clk,
    input  wire                                          rst,
    input  dcache_pkg::cpu_req_t                         s2_req_i,
    input  wire                                          hit_i,
    input  wire                                          victim_i,
    input  wire                                          victim_dirty_i,
    input  dcache_pkg::tagv_t [dcache_pkg::NUM_WAYS-1:0] victim_tag_i,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] victim_line_i,
    input  wire                                          ret_valid_i,
    input  wire                                          wr_valid_i,
    output logic                                         stall_o,
    output logic                                         resp_valid_o,
    output logic                                         refill_o,
    output dcache_pkg::mem_rd_t                          mem_rd_o,
    output dcache_pkg::mem_wr_t                          mem_wr_o
);

    dcache_pkg::miss_state_e state_q;
    dcache_pkg::miss_state_e state_d;

    logic req_valid;
    logic miss;
    logic wb_active;
    logic rd_active;

    assign req_valid = s2_req_i.rvalid | s2_req_i.wvalid;

    // first stage-2 cycle of a miss
    assign miss = (state_q == dcache_pkg::miss_idle) & req_valid & ~hit_i;

    //////////////////////////////
    // phase decode
    //////////////////////////////

    // dirty victim goes out first, then the fetch
    assign wb_active = (state_q == dcache_pkg::miss_writeback) | (miss & victim_dirty_i);
    assign rd_active = (state_q == dcache_pkg::miss_refill) | (miss & ~victim_dirty_i);

    // line arrives, install it this edge
    assign refill_o = rd_active & ret_valid_i;

    // stall drops in the ret_valid cycle
    assign stall_o      = (wb_active | rd_active) & ~refill_o;
    assign resp_valid_o = hit_i | refill_o;

    always_comb begin
        if (wb_active) begin
            state_d = wr_valid_i ? dcache_pkg::miss_refill : dcache_pkg::miss_writeback;
        end else if (rd_active) begin
            state_d = ret_valid_i ? dcache_pkg::miss_idle : dcache_pkg::miss_refill;
        end else begin
            state_d = dcache_pkg::miss_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= dcache_pkg::miss_idle;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // memory ports
    //////////////////////////////

    // refill address from the request
    always_comb begin
        mem_rd_o.req  = rd_active;
        mem_rd_o.addr = {s2_req_i.addr.tag, s2_req_i.addr.index,
                         {dcache_pkg::OFFSET_W{1'b0}}};
    end

    // write-back address from the victim tag
    // arrays keep re-reading this set while stalled, so data holds
    always_comb begin
        mem_wr_o.req  = wb_active;
        mem_wr_o.addr = {victim_tag_i[victim_i].tag, s2_req_i.addr.index,
                         {dcache_pkg::OFFSET_W{1'b0}}};
        mem_wr_o.data = victim_line_i[victim_i];
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                  clk,
    input  wire                  rst,
    input  dcache_pkg::cpu_req_t req_i,
    output logic                 stall_o,
    output logic                 resp_valid_o,
    output logic [31:0]          rdata_o,
    output dcache_pkg::mem_rd_t  mem_rd_o,
    input  wire                  ret_valid_i,
    input  dcache_pkg::line_t    ret_data_i,
    output dcache_pkg::mem_wr_t  mem_wr_o,
    input  wire                  wr_valid_i
);

    //////////////////////////////
    // stage 2 and array wires
    //////////////////////////////

    dcache_pkg::cpu_req_t s2_req;
    logic [dcache_pkg::INDEX_W-1:0] rd_index;

    // array outputs, one entry per way
    dcache_pkg::tagv_t [dcache_pkg::NUM_WAYS-1:0] way_tagv;
    dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] way_line;

    // lookup results
    logic [dcache_pkg::NUM_WAYS-1:0] hit_way;
    logic hit;
    dcache_pkg::line_t wr_line;
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::LINE_W/8-1:0] byte_we;

    // replacement and miss handling
    logic victim;
    logic victim_dirty;
    logic refill;

    dcache_req_stage u_req_stage (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .stall_i    (stall_o),
        .s2_req_o   (s2_req),
        .rd_index_o (rd_index)
    );

    // tag written only into the victim way on refill
    dcache_way way0 (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_index_i (s2_req.addr.index),
        .tag_we_i   (refill && (victim == 1'b0)),
        .wr_tag_i   (s2_req.addr.tag),
        .byte_we_i  (byte_we[0]),
        .wr_line_i  (wr_line),
        .tagv_o     (way_tagv[0]),
        .line_o     (way_line[0])
    );

    dcache_way way1 (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_index_i (s2_req.addr.index),
        .tag_we_i   (refill && (victim == 1'b1)),
        .wr_tag_i   (s2_req.addr.tag),
        .byte_we_i  (byte_we[1]),
        .wr_line_i  (wr_line),
        .tagv_o     (way_tagv[1]),
        .line_o     (way_line[1])
    );

    dcache_lookup u_lookup (
        .s2_req_i   (s2_req),
        .way_tagv_i (way_tagv),
        .way_line_i (way_line),
        .refill_i   (refill),
        .ret_data_i (ret_data_i),
        .victim_i   (victim),
        .hit_way_o  (hit_way),
        .hit_o      (hit),
        .rdata_o    (rdata_o),
        .wr_line_o  (wr_line),
        .byte_we_o  (byte_we)
    );

    dcache_replace u_replace (
        .clk            (clk),
        .rst            (rst),
        .index_i        (s2_req.addr.index),
        .hit_way_i      (hit_way),
        .is_write_i     (s2_req.wvalid),
        .refill_i       (refill),
        .victim_o       (victim),
        .victim_dirty_o (victim_dirty)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk            (clk),
        .rst            (rst),
        .s2_req_i       (s2_req),
        .hit_i          (hit),
        .victim_i       (victim),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (way_tagv),
        .victim_line_i  (way_line),
        .ret_valid_i    (ret_valid_i),
        .wr_valid_i     (wr_valid_i),
        .stall_o        (stall_o),
        .resp_valid_o   (resp_valid_o),
        .refill_o       (refill),
        .mem_rd_o       (mem_rd_o),
        .mem_wr_o       (mem_wr_o)
    );

endmodule

`default_nettype wire

// ==== verification/dcache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
    input  wire                 clk,
    input  wire                 rst,
    input  dcache_pkg::mem_rd_t mem_rd_i,
    output logic                ret_valid_o,
    output dcache_pkg::line_t   ret_data_o,
    input  dcache_pkg::mem_wr_t mem_wr_i,
    output logic                wr_valid_o,
    output int                  rd_count_o,
    output logic [31:0]         last_rd_addr_o,
    output int                  wb_count_o,
    output logic [31:0]         last_wb_addr_o,
    output dcache_pkg::line_t   last_wb_line_o
);

    // written-back lines keyed by line address
    dcache_pkg::line_t mem [logic [31:0]];

    logic        rd_busy;
    logic        wr_busy;
    int unsigned rd_wait;
    int unsigned wr_wait;

    // untouched lines hold the address pattern
    function automatic dcache_pkg::line_t fetch_line(input logic [31:0] line_addr);
        dcache_pkg::line_t data;
        if (mem.exists(line_addr)) begin
            data = mem[line_addr];
        end else begin
            for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
                data[w] = (line_addr + 32'(4 * w)) ^ 32'hA5A5_0000;
            end
        end
        return data;
    endfunction

    initial begin
        void'($urandom(32'h3703));
        ret_valid_o = 1'b0;
        ret_data_o  = '0;
        wr_valid_o  = 1'b0;
    end

    //////////////////////////////
    // line reads
    //////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            ret_valid_o    <= 1'b0;
            rd_busy        <= 1'b0;
            rd_wait        <= 0;
            rd_count_o     <= 0;
            last_rd_addr_o <= '0;
        end else if (ret_valid_o) begin
            // one beat since req drops at this edge
            ret_valid_o <= 1'b0;
        end else if (rd_busy && rd_wait == 0) begin
            ret_valid_o    <= 1'b1;
            ret_data_o     <= fetch_line(mem_rd_i.addr);
            rd_busy        <= 1'b0;
            rd_count_o     <= rd_count_o + 1;
            last_rd_addr_o <= mem_rd_i.addr;
        end else if (rd_busy) begin
            rd_wait <= rd_wait - 1;
        end else if (mem_rd_i.req) begin
            rd_busy <= 1'b1;
            rd_wait <= $urandom % 6;
        end
    end

    //////////////////////////////
    // line writes
    //////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            wr_valid_o     <= 1'b0;
            wr_busy        <= 1'b0;
            wr_wait        <= 0;
            wb_count_o     <= 0;
            last_wb_addr_o <= '0;
            last_wb_line_o <= '0;
        end else if (wr_valid_o) begin
            wr_valid_o <= 1'b0;
        end else if (wr_busy && wr_wait == 0) begin
            // line taken in this cycle
            mem[mem_wr_i.addr] = mem_wr_i.data;
            wr_valid_o     <= 1'b1;
            wr_busy        <= 1'b0;
            wb_count_o     <= wb_count_o + 1;
            last_wb_addr_o <= mem_wr_i.addr;
            last_wb_line_o <= mem_wr_i.data;
        end else if (wr_busy) begin
            wr_wait <= wr_wait - 1;
        end else if (mem_wr_i.req) begin
            wr_busy <= 1'b1;
            wr_wait <= $urandom % 6;
        end
    end

endmodule

`default_nettype wire

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int MAX_WAIT = 200;

    // stimulus and the expected outcome
    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        logic [3:0]  wsel;
        logic [31:0] wdata;
        logic        exp_miss;
        logic        exp_wb;
        logic [31:0] wb_addr;
    } op_t;

    logic                 clk;
    logic                 rst;
    dcache_pkg::cpu_req_t req;
    logic                 stall;
    logic                 resp_valid;
    logic [31:0]          rdata;
    dcache_pkg::mem_rd_t  mem_rd;
    logic                 ret_valid;
    dcache_pkg::line_t    ret_data;
    dcache_pkg::mem_wr_t  mem_wr;
    logic                 wr_valid;

    // memory side bookkeeping
    int                   rd_count;
    int                   wb_count;
    logic [31:0]          last_rd_addr;
    logic [31:0]          last_wb_addr;
    dcache_pkg::line_t    last_wb_line;

    op_t         ops [$];
    logic [31:0] shadow [logic [31:0]];
    int          errors;
    int          checks;
    int          timeouts;
    int          resp_count;

    dcache_top DUT (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .stall_o      (stall),
        .resp_valid_o (resp_valid),
        .rdata_o      (rdata),
        .mem_rd_o     (mem_rd),
        .ret_valid_i  (ret_valid),
        .ret_data_i   (ret_data),
        .mem_wr_o     (mem_wr),
        .wr_valid_i   (wr_valid)
    );

    dcache_mem_model mem_model (
        .clk            (clk),
        .rst            (rst),
        .mem_rd_i       (mem_rd),
        .ret_valid_o    (ret_valid),
        .ret_data_o     (ret_data),
        .mem_wr_i       (mem_wr),
        .wr_valid_o     (wr_valid),
        .rd_count_o     (rd_count),
        .last_rd_addr_o (last_rd_addr),
        .wb_count_o     (wb_count),
        .last_wb_addr_o (last_wb_addr),
        .last_wb_line_o (last_wb_line)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory as the cache should see it
    // untouched words keep the address pattern
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (shadow.exists(a)) begin
            return shadow[a];
        end else begin
            return a ^ 32'hA5A5_0000;
        end
    endfunction

    function automatic void store_word(input logic [31:0] addr, input logic [3:0] wsel,
                                       input logic [31:0] wdata);
        logic [31:0] mask;
        mask = {{8{wsel[3]}}, {8{wsel[2]}}, {8{wsel[1]}}, {8{wsel[0]}}};
        shadow[{addr[31:2], 2'b00}] = (expected_word(addr) & ~mask) | (wdata & mask);
    endfunction

    function automatic void add_op(input logic is_write, input logic [31:0] addr,
                                   input logic [3:0] wsel, input logic [31:0] wdata,
                                   input logic exp_miss, input logic exp_wb,
                                   input logic [31:0] wb_addr);
        ops.push_back('{is_write, addr, wsel, wdata, exp_miss, exp_wb, wb_addr});
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h got %h",
                     $time, name, expected, actual);
        end
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    // kind, address, wsel, wdata, miss, write-back, write-back address
    function automatic void fill_table();
        // set 5 holds two tags and then sees an eviction chain
        add_op(1'b0, 32'h0001_00A4, 4'h0, 32'h0, 1'b1, 1'b0, 32'h0);
        add_op(1'b0, 32'h0001_00A4, 4'h0, 32'h0, 1'b0, 1'b0, 32'h0);
        add_op(1'b1, 32'h0001_00A8, 4'h3, 32'h1234_5678, 1'b0, 1'b0, 32'h0);
        add_op(1'b0, 32'h0001_00A8, 4'h0, 32'h0, 1'b0, 1'b0, 32'h0);
        add_op(1'b0, 32'h0002_00B0, 4'h0, 32'h0, 1'b1, 1'b0, 32'h0);
        add_op(1'b0, 32'h0001_00A4, 4'h0, 32'h0, 1'b0, 1'b0, 32'h0);
        add_op(1'b0, 32'h0003_00A0, 4'h0, 32'h0, 1'b1, 1'b0, 32'h0);
        add_op(1'b0, 32'h0002_00B0, 4'h0, 32'h0, 1'b1, 1'b1, 32'h0001_00A0);
        add_op(1'b0, 32'h0001_00A8, 4'h0, 32'h0, 1'b1, 1'b0, 32'h0);
        // set 9 has write misses merged into the refill
        add_op(1'b1, 32'h0004_0124, 4'hC, 32'hDEAD_BEEF, 1'b1, 1'b0, 32'h0);
        add_op(1'b0, 32'h0004_0124, 4'h0, 32'h0, 1'b0, 1'b0, 32'h0);
        add_op(1'b1, 32'h0005_0120, 4'hF, 32'hCAFE_F00D, 1'b1, 1'b0, 32'h0);
        add_op(1'b0, 32'h0006_0128, 4'h0, 32'h0, 1'b1, 1'b1, 32'h0004_0120);
        add_op(1'b0, 32'h0007_0120, 4'h0, 32'h0, 1'b1, 1'b1, 32'h0005_0120);
        add_op(1'b0, 32'h0005_0120, 4'h0, 32'h0, 1'b1, 1'b0, 32'h0);
        add_op(1'b1, 32'h0005_012C, 4'h4, 32'h00AB_0000, 1'b0, 1'b0, 32'h0);
        add_op(1'b0, 32'h0005_012C, 4'h0, 32'h0, 1'b0, 1'b0, 32'h0);
    endfunction

    //////////////////////////////
    // one request from issue to response
    //////////////////////////////

    task automatic run_op(input op_t op);
        dcache_pkg::cpu_req_t r;
        int                   rd_base;
        int                   wb_base;
        int                   waited;
        logic                 accepted;
        logic                 got;
        logic [31:0]          got_rdata;
        r.rvalid  = !op.is_write;
        r.wvalid  = op.is_write;
        r.addr    = op.addr;
        r.wsel    = op.is_write ? op.wsel : 4'h0;
        r.wdata   = op.is_write ? op.wdata : 32'h0;
        rd_base   = rd_count;
        wb_base   = wb_count;
        accepted  = 1'b0;
        got       = 1'b0;
        got_rdata = '0;
        waited    = 0;
        req <= r;
        while (!accepted && waited < MAX_WAIT) begin
            @(posedge clk);
            waited++;
            accepted = !stall;
        end
        req <= '0;
        waited = 0;
        while (accepted && !got && waited < MAX_WAIT) begin
            @(posedge clk);
            waited++;
            if (resp_valid) begin
                got       = 1'b1;
                got_rdata = rdata;
            end else begin
                // request still outstanding, the pipe must hold
                check_value("stall_o", 32'h1, 32'(stall));
            end
        end
        if (!accepted || !got) begin
            errors++;
            timeouts++;
            $display("timeout: request to address %h was not answered in time", op.addr);
        end else begin
            if (op.is_write) begin
                check_value("rdata_o", 32'h0, got_rdata);
            end else begin
                check_value("rdata_o", expected_word(op.addr), got_rdata);
            end
            check_value("line reads", 32'(op.exp_miss), rd_count - rd_base);
            if (op.exp_miss) begin
                check_value("mem_rd_o.addr", {op.addr[31:5], 5'b0}, last_rd_addr);
            end else begin
                // hit answered the cycle after acceptance
                check_value("resp_valid_o latency", 1, waited);
            end
            check_value("write-backs", 32'(op.exp_wb), wb_count - wb_base);
            if (op.exp_wb) begin
                check_value("mem_wr_o.addr", op.wb_addr, last_wb_addr);
                for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
                    check_value("mem_wr_o.data", expected_word(op.wb_addr + 32'(4 * w)),
                                last_wb_line[w]);
                end
            end
            if (op.is_write) begin
                store_word(op.addr, op.wsel, op.wdata);
            end
        end
    endtask

    // count response pulses and keep the line read apart from the write-back
    always @(posedge clk) begin
        if (rst) begin
            if (resp_valid) begin
                resp_count <= resp_count + 1;
            end
            assert (!(mem_rd.req && mem_wr.req)) else begin
                errors++;
                $display("at %0t ns the line read and the write-back were requested together",
                         $time);
            end
        end
    end

    initial begin
        rst        = 1'b0;
        req        = '0;
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        resp_count = 0;
        fill_table();
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        // quiet after reset
        check_value("stall_o", 32'h0, 32'(stall));
        check_value("resp_valid_o", 32'h0, 32'(resp_valid));
        check_value("mem_rd_o.req", 32'h0, 32'(mem_rd.req));
        check_value("mem_wr_o.req", 32'h0, 32'(mem_wr.req));
        foreach (ops[i]) begin
            if (timeouts == 0) begin
                run_op(ops[i]);
            end
        end
        // a stray response would show in the idle tail
        repeat (4) @(posedge clk);
        check_value("resp_valid_o pulses", ops.size(), resp_count);
        $display("summary: %0d checks, %0d errors, %0d timeouts, %0d responses",
                 checks, errors, timeouts, resp_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/dcache_pkg.sv
verilog/dcache_req_stage.sv
verilog/dcache_way.sv
verilog/dcache_lookup.sv
verilog/dcache_replace.sv
verilog/dcache_miss_ctrl.sv
verilog/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv
